//--- src/adam_lsbp_pkg.sv
package adam_lsbp_pkg;

    // upper bound for the number of timer slots
    localparam int MAX_TIMERS = 8;

    // bus level words
    typedef logic [31:0] data_t;
    typedef logic [11:0] addr_t;

    // decoded address fields
    typedef logic [3:0] slot_t;
    typedef logic [2:0] offs_t;

    // slot number sits in the upper address nibble
    localparam int SLOT_MSB = 11;
    localparam int SLOT_LSB = 8;

    // word offset inside a slot, byte lanes ignored
    localparam int OFFS_MSB = 4;
    localparam int OFFS_LSB = 2;

endpackage

//--- src/adam_timer_pkg.sv
package adam_timer_pkg;

    // timer register map
    typedef enum adam_lsbp_pkg::offs_t {
        TMR_CTRL     = 3'd0,
        TMR_PRESCALE = 3'd1,
        TMR_LIMIT    = 3'd2,
        // read only
        TMR_COUNT    = 3'd3
    } tmr_reg_e;

    // interrupt controller register map
    typedef enum adam_lsbp_pkg::offs_t {
        // write 1s to clear
        INTC_PENDING = 3'd0,
        INTC_MASK    = 3'd1
    } intc_reg_e;

    // CTRL bit positions
    localparam int CTRL_EN_BIT = 0;

endpackage

//--- src/adam_reg_if.sv
interface adam_reg_if #(
    parameter int NO_TIMERS = 4
) ();

    // one slot per timer plus the interrupt controller
    logic [NO_TIMERS:0]   sel;
    logic                 req;
    logic                 write;
    adam_lsbp_pkg::offs_t offs;
    adam_lsbp_pkg::data_t wdata;

    // response entries, one per slot
    adam_lsbp_pkg::data_t rdata [NO_TIMERS+1];
    logic                 err   [NO_TIMERS+1];

    modport master (
        output sel, req, write, offs, wdata,
        input  rdata, err
    );

    modport slave (
        input  sel, req, write, offs, wdata,
        output rdata, err
    );

endinterface

//--- src/adam_lsbp_apb_decode.sv
module adam_lsbp_apb_decode #(
    parameter int NO_TIMERS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic                 pause_req,
    input  adam_lsbp_pkg::addr_t paddr,
    input  adam_lsbp_pkg::data_t pwdata,
    output adam_lsbp_pkg::data_t prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 pause_ack,
    adam_reg_if.master           bus
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        RESP,
        PAUSED
    } state_e;

    state_e               state;
    state_e               state_next;
    adam_lsbp_pkg::slot_t slot;
    logic [NO_TIMERS:0]   sel_q;
    adam_lsbp_pkg::data_t rdata_mux;
    logic                 err_mux;

    if (NO_TIMERS < 1 || NO_TIMERS > adam_lsbp_pkg::MAX_TIMERS) begin : g_bad_cfg
        $error("NO_TIMERS out of range");
    end

    // address split, paddr is stable for the whole access
    assign slot      = paddr[adam_lsbp_pkg::SLOT_MSB:adam_lsbp_pkg::SLOT_LSB];
    assign bus.offs  = paddr[adam_lsbp_pkg::OFFS_MSB:adam_lsbp_pkg::OFFS_LSB];
    assign bus.write = pwrite;
    assign bus.wdata = pwdata;
    assign bus.req   = (state == ISSUE);

    // one-hot slot select, all zero for unmapped slots
    always_comb begin
        for (int i = 0; i <= NO_TIMERS; i++) begin
            bus.sel[i] = (slot == adam_lsbp_pkg::slot_t'(i));
        end
    end

    // pause is only granted from IDLE, i.e. between accesses
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (pause_req) begin
                    state_next = PAUSED;
                end else if (psel) begin
                    state_next = ISSUE;
                end
            end
            ISSUE:   state_next = RESP;
            RESP:    state_next = IDLE;
            PAUSED: begin
                if (!pause_req) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            sel_q <= '0;
        end else begin
            state <= state_next;
            if (state == ISSUE) begin
                sel_q <= bus.sel;
            end
        end
    end

    // no slot hit means a local error with zero data
    always_comb begin
        rdata_mux = '0;
        err_mux   = 1'b1;
        for (int i = 0; i <= NO_TIMERS; i++) begin
            if (sel_q[i]) begin
                rdata_mux = bus.rdata[i];
                err_mux   = bus.err[i];
            end
        end
    end

    assign pready    = (state == RESP);
    assign pslverr   = pready & err_mux;
    assign prdata    = pready ? rdata_mux : '0;
    assign pause_ack = (state == PAUSED);

endmodule

//--- src/adam_lsbp_timer.sv
module adam_lsbp_timer #(
    parameter int SLOT = 0
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pause,
    adam_reg_if.slave bus,
    output logic      evt
);

    logic                 en;
    adam_lsbp_pkg::data_t prescale;
    adam_lsbp_pkg::data_t limit;
    adam_lsbp_pkg::data_t count;
    adam_lsbp_pkg::data_t pre_cnt;
    adam_lsbp_pkg::data_t rdata_q;
    logic                 err_q;
    logic                 hit;
    logic                 tick;
    logic                 wrap;

    assign hit = bus.req & bus.sel[SLOT];

    // one tick every prescale+1 cycles, frozen while paused
    assign tick = en & ~pause & (pre_cnt >= prescale);
    // >= keeps count bounded when limit is lowered under it
    assign wrap = (count >= limit);
    assign evt  = tick & wrap;

    assign bus.rdata[SLOT] = rdata_q;
    assign bus.err[SLOT]   = err_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en       <= 1'b0;
            prescale <= '0;
            limit    <= '0;
            count    <= '0;
            pre_cnt  <= '0;
            rdata_q  <= '0;
            err_q    <= 1'b0;
        end else begin
            // prescaler and counter
            if (!en) begin
                pre_cnt <= '0;
            end else if (!pause) begin
                if (tick) begin
                    pre_cnt <= '0;
                    count   <= wrap ? '0 : count + 1'b1;
                end else begin
                    pre_cnt <= pre_cnt + 1'b1;
                end
            end

            // register access, response lands one cycle after req
            rdata_q <= '0;
            err_q   <= 1'b0;
            if (hit) begin
                case (bus.offs)
                    adam_timer_pkg::TMR_CTRL: begin
                        if (bus.write) begin
                            en <= bus.wdata[adam_timer_pkg::CTRL_EN_BIT];
                        end else begin
                            rdata_q <= adam_lsbp_pkg::data_t'(en);
                        end
                    end
                    adam_timer_pkg::TMR_PRESCALE: begin
                        if (bus.write) begin
                            prescale <= bus.wdata;
                        end else begin
                            rdata_q <= prescale;
                        end
                    end
                    adam_timer_pkg::TMR_LIMIT: begin
                        if (bus.write) begin
                            limit <= bus.wdata;
                        end else begin
                            rdata_q <= limit;
                        end
                    end
                    adam_timer_pkg::TMR_COUNT: begin
                        if (bus.write) begin
                            err_q <= 1'b1;
                        end else begin
                            rdata_q <= count;
                        end
                    end
                    default: err_q <= 1'b1;
                endcase
            end
        end
    end

endmodule

//--- src/adam_lsbp_intc.sv
module adam_lsbp_intc #(
    parameter int NO_TIMERS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [NO_TIMERS-1:0] evt,
    adam_reg_if.slave            bus,
    output logic                 irq
);

    logic [NO_TIMERS-1:0] pending;
    logic [NO_TIMERS-1:0] mask;
    adam_lsbp_pkg::data_t rdata_q;
    logic                 err_q;
    logic                 hit;

    // the controller sits right after the last timer
    assign hit = bus.req & bus.sel[NO_TIMERS];

    assign bus.rdata[NO_TIMERS] = rdata_q;
    assign bus.err[NO_TIMERS]   = err_q;

    assign irq = |(pending & mask);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
            mask    <= '0;
            rdata_q <= '0;
            err_q   <= 1'b0;
        end else begin
            rdata_q <= '0;
            err_q   <= 1'b0;
            // sticky, a new event beats a clear in the same cycle
            pending <= pending | evt;
            if (hit) begin
                case (bus.offs)
                    adam_timer_pkg::INTC_PENDING: begin
                        if (bus.write) begin
                            pending <= (pending & ~bus.wdata[NO_TIMERS-1:0]) | evt;
                        end else begin
                            rdata_q <= adam_lsbp_pkg::data_t'(pending);
                        end
                    end
                    adam_timer_pkg::INTC_MASK: begin
                        if (bus.write) begin
                            mask <= bus.wdata[NO_TIMERS-1:0];
                        end else begin
                            rdata_q <= adam_lsbp_pkg::data_t'(mask);
                        end
                    end
                    default: err_q <= 1'b1;
                endcase
            end
        end
    end

endmodule

//--- src/adam_lsbp.sv
module adam_lsbp #(
    parameter int NO_TIMERS = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic                 pause_req,
    input  adam_lsbp_pkg::addr_t paddr,
    input  adam_lsbp_pkg::data_t pwdata,
    output adam_lsbp_pkg::data_t prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 pause_ack,
    output logic                 irq
);

    adam_reg_if #(.NO_TIMERS (NO_TIMERS)) reg_bus ();

    // limit events, one per timer
    logic [NO_TIMERS-1:0] evt;

    adam_lsbp_apb_decode #(
        .NO_TIMERS (NO_TIMERS)
    ) apb_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pause_req (pause_req),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .pause_ack (pause_ack),
        .bus       (reg_bus)
    );

    for (genvar i = 0; i < NO_TIMERS; i++) begin : g_timer
        adam_lsbp_timer #(
            .SLOT (i)
        ) timer (
            .clk   (clk),
            .rst_n (rst_n),
            .pause (pause_ack),
            .bus   (reg_bus),
            .evt   (evt[i])
        );
    end

    adam_lsbp_intc #(
        .NO_TIMERS (NO_TIMERS)
    ) intc (
        .clk   (clk),
        .rst_n (rst_n),
        .evt   (evt),
        .bus   (reg_bus),
        .irq   (irq)
    );

endmodule

//--- dv/adam_lsbp_chk.sv
module adam_lsbp_chk (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 req,
    input logic                 pause,
    input adam_lsbp_pkg::data_t count
);

    // no request may leave the decode stage while paused
    no_req_in_pause: assert property (
        @(posedge clk) disable iff (!rst_n) !(req && pause)
    ) else $error("req issued while pause_ack is high");

    req_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) req |=> !req
    ) else $error("req held for more than one cycle");

    // counter frozen for every paused cycle
    count_frozen: assert property (
        @(posedge clk) disable iff (!rst_n) pause |=> $stable(count)
    ) else $error("timer count moved while paused");

endmodule

//--- dv/adam_lsbp_scoreboard.sv
module adam_lsbp_scoreboard #(
    parameter int NO_TIMERS = 4
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 psel,
    input logic                 penable,
    input logic                 pwrite,
    input logic                 pready,
    input logic                 pslverr,
    input logic                 irq,
    input adam_lsbp_pkg::addr_t paddr,
    input adam_lsbp_pkg::data_t pwdata,
    input adam_lsbp_pkg::data_t prdata
);

    // register model starting from reset values
    logic                 en_m  [NO_TIMERS] = '{default: 1'b0};
    adam_lsbp_pkg::data_t pre_m [NO_TIMERS] = '{default: '0};
    adam_lsbp_pkg::data_t lim_m [NO_TIMERS] = '{default: '0};
    logic [NO_TIMERS-1:0] mask_m = '0;
    logic [NO_TIMERS-1:0] pend_m = '0;
    // pending bits of running timers are unknown until the test says otherwise
    logic [NO_TIMERS-1:0] known  = '1;
    string                test_name = "";
    int                   test_errors = 0;
    int                   tests = 0;
    int                   failed_tests = 0;
    int                   checks = 0;
    int                   errors = 0;

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("test %-9s %s, %0d errors", test_name,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
    endtask

    task automatic compare(input string what, input adam_lsbp_pkg::data_t exp,
                           input adam_lsbp_pkg::data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            test_errors++;
            $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_max(input string what, input adam_lsbp_pkg::data_t bound,
                               input adam_lsbp_pkg::data_t act);
        checks++;
        if (!(act <= bound)) begin
            errors++;
            test_errors++;
            $display("FAIL %s %s expected at most %h actual %h", test_name, what, bound, act);
        end
    endtask

    task automatic record(input string what, input logic ok);
        checks++;
        if (!ok) begin
            errors++;
            test_errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    task automatic expect_pending(input int t, input logic value);
        pend_m[t] = value;
        known[t]  = 1'b1;
    endtask

    // one sample per access in the middle of the pready cycle
    always @(negedge clk) begin
        adam_lsbp_pkg::slot_t slot;
        adam_lsbp_pkg::offs_t offs;
        adam_lsbp_pkg::data_t exp;
        adam_lsbp_pkg::data_t care;
        logic                 err;
        logic                 cmp;
        if (rst_n && psel && penable && pready) begin
            slot = paddr[adam_lsbp_pkg::SLOT_MSB:adam_lsbp_pkg::SLOT_LSB];
            offs = paddr[adam_lsbp_pkg::OFFS_MSB:adam_lsbp_pkg::OFFS_LSB];
            exp  = '0;
            err  = 1'b1;
            cmp  = !pwrite;
            if (slot < NO_TIMERS) begin
                case (offs)
                    adam_timer_pkg::TMR_CTRL: begin
                        err = 1'b0;
                        exp = adam_lsbp_pkg::data_t'(en_m[slot]);
                        if (pwrite) begin
                            en_m[slot] = pwdata[adam_timer_pkg::CTRL_EN_BIT];
                            if (en_m[slot]) begin
                                known[slot] = 1'b0;
                            end
                        end
                    end
                    adam_timer_pkg::TMR_PRESCALE: begin
                        err = 1'b0;
                        exp = pre_m[slot];
                        if (pwrite) begin
                            pre_m[slot] = pwdata;
                        end
                    end
                    adam_timer_pkg::TMR_LIMIT: begin
                        err = 1'b0;
                        exp = lim_m[slot];
                        if (pwrite) begin
                            lim_m[slot] = pwdata;
                        end
                    end
                    adam_timer_pkg::TMR_COUNT: begin
                        if (!pwrite) begin
                            err = 1'b0;
                            cmp = 1'b0;
                            compare_max("count", lim_m[slot], prdata);
                        end
                    end
                    default: ;
                endcase
            end else if (slot == NO_TIMERS) begin
                case (offs)
                    adam_timer_pkg::INTC_PENDING: begin
                        err = 1'b0;
                        cmp = 1'b0;
                        if (pwrite) begin
                            for (int i = 0; i < NO_TIMERS; i++) begin
                                if (pwdata[i] && !en_m[i]) begin
                                    pend_m[i] = 1'b0;
                                    known[i]  = 1'b1;
                                end
                            end
                        end else begin
                            care = ~adam_lsbp_pkg::data_t'(~known);
                            compare("pending", adam_lsbp_pkg::data_t'(pend_m) & care,
                                    prdata & care);
                        end
                    end
                    adam_timer_pkg::INTC_MASK: begin
                        err = 1'b0;
                        exp = adam_lsbp_pkg::data_t'(mask_m);
                        if (pwrite) begin
                            mask_m = pwdata[NO_TIMERS-1:0];
                        end
                    end
                    default: ;
                endcase
            end
            compare("pslverr", err, pslverr);
            if (cmp) begin
                compare("prdata", exp, prdata);
            end
            if (&known) begin
                compare("irq", |(pend_m & mask_m), irq);
            end
        end
    end

endmodule

//--- dv/adam_lsbp_tb.sv
module adam_lsbp_tb;

    localparam int NO_TIMERS = 4;
    localparam int N_ERR     = 24;
    localparam int N_CLR     = 10;
    localparam int MAX_LIMIT = 15;
    // accesses of the readback, error, event, clear and pause tests
    localparam int N_ACC = (4 * NO_TIMERS + 2) + (N_ERR + 2 * NO_TIMERS + 1)
                         + 8 * NO_TIMERS + 3 * N_CLR + 3;
    // 4 cycles per access plus the irq waits, reset, pause hold and a margin
    localparam int MAX_CYCLES = N_ACC * 4 + NO_TIMERS * (MAX_LIMIT + 5) + 4 + 16 + 200;

    logic                 clk;
    logic                 rst_n;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic                 pause_req;
    adam_lsbp_pkg::addr_t paddr;
    adam_lsbp_pkg::data_t pwdata;
    adam_lsbp_pkg::data_t prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 pause_ack;
    logic                 irq;
    integer               seed = 97247;
    int                   cycles = 0;

    adam_lsbp #(.NO_TIMERS (NO_TIMERS)) dut (.*);

    adam_lsbp_scoreboard #(.NO_TIMERS (NO_TIMERS)) sb (.*);

    bind adam_lsbp_timer adam_lsbp_chk timer_chk (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (bus.req),
        .pause (pause),
        .count (count)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout, run still busy after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic adam_lsbp_pkg::addr_t addr_of(input int slot, input int offs);
        return adam_lsbp_pkg::addr_t'((slot << adam_lsbp_pkg::SLOT_LSB)
                                      | (offs << adam_lsbp_pkg::OFFS_LSB));
    endfunction

    // one APB transfer with inputs changed just after the rising edge
    task automatic access(input logic wr, input adam_lsbp_pkg::addr_t addr,
                          input adam_lsbp_pkg::data_t wdata);
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        do begin
            @(negedge clk);
        end while (!pready);
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input adam_lsbp_pkg::addr_t addr, input adam_lsbp_pkg::data_t wdata);
        access(1'b1, addr, wdata);
    endtask

    task automatic read_reg(input adam_lsbp_pkg::addr_t addr);
        access(1'b0, addr, '0);
    endtask

    initial begin
        adam_lsbp_pkg::data_t r;
        int                   lim;
        int                   n;
        int                   hold;
        int                   slot;
        int                   offs;
        logic                 wr;
        logic                 early;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pause_req = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        sb.start_test("readback");
        for (int t = 0; t < NO_TIMERS; t++) begin
            write_reg(addr_of(t, adam_timer_pkg::TMR_PRESCALE), $random(seed));
            write_reg(addr_of(t, adam_timer_pkg::TMR_LIMIT), $random(seed));
            read_reg(addr_of(t, adam_timer_pkg::TMR_PRESCALE));
            read_reg(addr_of(t, adam_timer_pkg::TMR_LIMIT));
        end
        write_reg(addr_of(NO_TIMERS, adam_timer_pkg::INTC_MASK), $random(seed));
        read_reg(addr_of(NO_TIMERS, adam_timer_pkg::INTC_MASK));
        sb.end_test();

        sb.start_test("errors");
        for (int i = 0; i < N_ERR; i++) begin
            r    = $random(seed);
            wr   = r[2];
            offs = r[7:5];
            case (r[1:0])
                // unmapped slot
                2'd0: slot = NO_TIMERS + 1 + int'(r[31:8] % (15 - NO_TIMERS));
                2'd1: begin
                    slot = r[9:8] % NO_TIMERS;
                    offs = 4 + r[6:5];
                end
                2'd2: begin
                    slot = NO_TIMERS;
                    offs = 2 + r[7:5] % 6;
                end
                default: begin
                    slot = r[9:8] % NO_TIMERS;
                    offs = adam_timer_pkg::TMR_COUNT;
                    wr   = 1'b1;
                end
            endcase
            access(wr, addr_of(slot, offs), $random(seed));
        end
        for (int t = 0; t < NO_TIMERS; t++) begin
            read_reg(addr_of(t, adam_timer_pkg::TMR_PRESCALE));
            read_reg(addr_of(t, adam_timer_pkg::TMR_LIMIT));
        end
        read_reg(addr_of(NO_TIMERS, adam_timer_pkg::INTC_MASK));
        sb.end_test();

        sb.start_test("event");
        for (int t = 0; t < NO_TIMERS; t++) begin
            lim = 1 + int'($unsigned($random(seed)) % MAX_LIMIT);
            write_reg(addr_of(t, adam_timer_pkg::TMR_LIMIT), lim);
            write_reg(addr_of(t, adam_timer_pkg::TMR_PRESCALE), '0);
            write_reg(addr_of(NO_TIMERS, adam_timer_pkg::INTC_MASK), 1 << t);
            write_reg(addr_of(t, adam_timer_pkg::TMR_CTRL), 1);
            // wrap after limit+1 ticks and pending one cycle later
            n = 0;
            while (!irq && n < lim + 4) begin
                @(negedge clk);
                n++;
            end
            sb.record("irq did not rise within limit+4 cycles", irq);
            read_reg(addr_of(t, adam_timer_pkg::TMR_COUNT));
            read_reg(addr_of(t, adam_timer_pkg::TMR_COUNT));
            write_reg(addr_of(t, adam_timer_pkg::TMR_CTRL), 0);
            sb.expect_pending(t, 1'b1);
            read_reg(addr_of(NO_TIMERS, adam_timer_pkg::INTC_PENDING));
        end
        sb.end_test();

        sb.start_test("clear");
        for (int i = 0; i < N_CLR; i++) begin
            write_reg(addr_of(NO_TIMERS, adam_timer_pkg::INTC_MASK), $random(seed));
            write_reg(addr_of(NO_TIMERS, adam_timer_pkg::INTC_PENDING),
                      1 << ($unsigned($random(seed)) % NO_TIMERS));
            read_reg(addr_of(NO_TIMERS, adam_timer_pkg::INTC_PENDING));
        end
        sb.end_test();

        sb.start_test("pause");
        // timer 0 keeps counting so the pause has a count to freeze
        write_reg(addr_of(0, adam_timer_pkg::TMR_LIMIT), 32'h0010_0000 | $random(seed));
        write_reg(addr_of(0, adam_timer_pkg::TMR_CTRL), 1);
        @(posedge clk);
        #2;
        pause_req = 1'b1;
        n = 0;
        while (!pause_ack && n < 4) begin
            @(negedge clk);
            n++;
        end
        sb.record("pause_ack did not rise", pause_ack);
        hold  = 4 + int'($unsigned($random(seed)) % 8);
        early = 1'b0;
        fork
            read_reg(addr_of(0, adam_timer_pkg::TMR_LIMIT));
            begin
                repeat (hold) begin
                    @(negedge clk);
                    early = early | pready;
                end
                @(posedge clk);
                #2;
                pause_req = 1'b0;
            end
        join
        sb.record("pready rose while paused", !early);
        sb.record("pause_ack stayed high after release", !pause_ack);
        sb.end_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 sb.tests, sb.failed_tests, sb.checks, sb.errors);
        if (sb.errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- build.f
src/adam_lsbp_pkg.sv
src/adam_timer_pkg.sv
src/adam_reg_if.sv
src/adam_lsbp_apb_decode.sv
src/adam_lsbp_timer.sv
src/adam_lsbp_intc.sv
src/adam_lsbp.sv
dv/adam_lsbp_chk.sv
dv/adam_lsbp_scoreboard.sv
dv/adam_lsbp_tb.sv

//--- Bender.yml
package:
  name: adam_lsbp

sources:
  - src/adam_lsbp_pkg.sv
  - src/adam_timer_pkg.sv
  - src/adam_reg_if.sv
  - src/adam_lsbp_apb_decode.sv
  - src/adam_lsbp_timer.sv
  - src/adam_lsbp_intc.sv
  - src/adam_lsbp.sv
  - target: simulation
    files:
      - dv/adam_lsbp_chk.sv
      - dv/adam_lsbp_scoreboard.sv
      - dv/adam_lsbp_tb.sv
